//--- i3c_standby_settings.svh
// Build-time settings of the I3C standby receive path
`ifndef I3C_STANDBY_SETTINGS_SVH
`define I3C_STANDBY_SETTINGS_SVH

// Static address answered by this target
`define STATIC_ADDR 7'h22

// Entries in the RX buffer, a power of two of 2 or more
`define RX_BUF_DEPTH 4

// Flops per line in the SCL/SDA synchronizers
`define SYNC_STAGES 2

`endif

//--- i3c_standby_pkg.sv
// Bus event, received byte and RX buffer entry types
`default_nettype none

package i3c_standby_pkg;

  // One cycle flags from the bus monitor
  typedef struct packed {
    logic start;
    logic stop;
    logic scl_rise;
    logic sda;
  } bus_event_t;

  // Header or SDR data byte from the deserializer
  typedef struct packed {
    logic [7:0] data;
    logic       is_header;
    logic       ninth;
    logic       parity_ok;
  } rx_byte_t;

  // Data byte or flush marker headed for the RX queue
  typedef struct packed {
    logic [7:0] data;
    logic       flush;
  } rx_entry_t;

endpackage

`default_nettype wire

//--- bus_monitor.sv
// Bus monitor with SCL/SDA synchronizers and START, STOP and SCL rise detection
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"
`default_nettype none

module bus_monitor
  import i3c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       enable_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t event_o
);

  logic [`SYNC_STAGES-1:0] scl_sync_q;
  logic [`SYNC_STAGES-1:0] sda_sync_q;
  logic                    scl_prev_q;
  logic                    sda_prev_q;
  logic                    scl_cur;
  logic                    sda_cur;
  bus_event_t              event_d;

  assign scl_cur = scl_sync_q[`SYNC_STAGES-1];
  assign sda_cur = sda_sync_q[`SYNC_STAGES-1];

  // Lines idle high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[`SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[`SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_cur;
      sda_prev_q <= sda_cur;
    end
  end

  // SDA edges while SCL stays high are bus conditions
  always_comb begin
    event_d.start    = scl_prev_q && scl_cur && sda_prev_q && !sda_cur;
    event_d.stop     = scl_prev_q && scl_cur && !sda_prev_q && sda_cur;
    event_d.scl_rise = !scl_prev_q && scl_cur;
    event_d.sda      = sda_cur;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      event_o <= '0;
    end else begin
      event_o <= enable_i ? event_d : '0;
    end
  end

  // Coincident SCL and SDA edges would hide a START or STOP
  a_no_dual_edge: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !((scl_cur != scl_prev_q) && (sda_cur != sda_prev_q))
  );

endmodule

`default_nettype wire

//--- sdr_deserializer.sv
// SDR deserializer with header and data framing, T-bit parity check and ACK drive
`timescale 1ns/1ps
`default_nettype none

module sdr_deserializer
  import i3c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  bus_event_t event_i,
  input  logic       ack_req_i,
  output logic       byte_valid_o,
  output rx_byte_t   byte_o,
  output logic       sda_o
);

  localparam int PHASE_W = 8;

  logic [3:0]         bit_cnt_q;
  logic               hdr_q;
  logic [7:0]         shift_q;
  logic [7:0]         shift_next;
  logic               ninth_slot;
  logic               hdr_done;
  logic               data_done;
  logic [PHASE_W-1:0] phase_cnt_q;
  logic [PHASE_W-1:0] half_q;
  logic               scl_low_q;
  logic               scl_fall;
  logic               ack_drive_q;

  assign shift_next = {shift_q[6:0], event_i.sda};
  assign ninth_slot = (bit_cnt_q == 4'd8);
  assign hdr_done   = event_i.scl_rise && hdr_q && (bit_cnt_q == 4'd7);
  assign data_done  = event_i.scl_rise && !hdr_q && ninth_slot;

  // Falling edge estimated half an SCL period after each rise
  assign scl_fall   = !event_i.scl_rise && !scl_low_q && (phase_cnt_q == half_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt_q    <= '0;
      hdr_q        <= 1'b0;
      byte_valid_o <= 1'b0;
    end else begin
      byte_valid_o <= hdr_done || data_done;
      if (event_i.start) begin
        bit_cnt_q <= '0;
        hdr_q     <= 1'b1;
      end else if (event_i.stop) begin
        bit_cnt_q <= '0;
        hdr_q     <= 1'b0;
      end else if (event_i.scl_rise) begin
        if (ninth_slot) begin
          bit_cnt_q <= '0;
          hdr_q     <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end
    end
  end

  // MSB first, ninth bit kept out of the shifter
  always_ff @(posedge clk_i) begin
    if (event_i.scl_rise && !ninth_slot) begin
      shift_q <= shift_next;
    end
    if (hdr_done) begin
      byte_o.data      <= shift_next;
      byte_o.is_header <= 1'b1;
      byte_o.ninth     <= 1'b0;
      byte_o.parity_ok <= 1'b1;
    end else if (data_done) begin
      byte_o.data      <= shift_q;
      byte_o.is_header <= 1'b0;
      byte_o.ninth     <= event_i.sda;
      byte_o.parity_ok <= ^{shift_q, event_i.sda};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_cnt_q <= '0;
      half_q      <= '1;
      scl_low_q   <= 1'b1;
    end else if (event_i.scl_rise) begin
      half_q      <= phase_cnt_q >> 1;
      phase_cnt_q <= '0;
      scl_low_q   <= 1'b0;
    end else begin
      if (phase_cnt_q != '1) begin
        phase_cnt_q <= phase_cnt_q + 1'b1;
      end
      if (scl_fall) begin
        scl_low_q <= 1'b1;
      end
    end
  end

  // Pulls SDA from the fall after bit 8 to the fall after the ACK bit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_drive_q <= 1'b0;
    end else if (event_i.start || event_i.stop || !ack_req_i) begin
      ack_drive_q <= 1'b0;
    end else if (scl_fall) begin
      ack_drive_q <= hdr_q && ninth_slot;
    end
  end

  assign sda_o = !ack_drive_q;

  a_ack_in_ninth_slot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (!sda_o && event_i.scl_rise) |-> (hdr_q && ninth_slot)
  );

endmodule

`default_nettype wire

//--- target_addr_filter.sv
// Target address filter with ACK decision, transfer state and RX entry generation
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"
`default_nettype none

module target_addr_filter
  import i3c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       byte_valid_i,
  input  rx_byte_t   byte_i,
  input  logic       stop_i,
  input  logic [6:0] dyn_addr_i,
  input  logic       dyn_addr_valid_i,
  output logic       ack_req_o,
  output logic       push_o,
  output rx_entry_t  entry_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o
);

  typedef enum logic [1:0] {
    XFER_NONE,
    XFER_OWN_WR,
    XFER_BCAST,
    XFER_OTHER
  } xfer_e;

  xfer_e      xfer_q;
  logic       pushed_q;
  logic [6:0] hdr_addr;
  logic       hdr_rnw;
  logic       own_match;
  logic       bcast_match;
  logic       hdr_valid;
  logic       data_valid;
  logic       data_push;
  logic       flush_push;

  assign hdr_addr    = byte_i.data[7:1];
  assign hdr_rnw     = byte_i.data[0];
  assign own_match   = (hdr_addr == `STATIC_ADDR) ||
                       (dyn_addr_valid_i && (hdr_addr == dyn_addr_i));
  assign bcast_match = (hdr_addr == 7'h7E);
  assign hdr_valid   = byte_valid_i && byte_i.is_header;
  assign data_valid  = byte_valid_i && !byte_i.is_header;
  assign data_push   = data_valid && (xfer_q == XFER_OWN_WR) && byte_i.parity_ok;
  assign flush_push  = stop_i && (xfer_q == XFER_OWN_WR) && pushed_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      xfer_q           <= XFER_NONE;
      pushed_q         <= 1'b0;
      ack_req_o        <= 1'b0;
      push_o           <= 1'b0;
      bus_addr_valid_o <= 1'b0;
    end else begin
      push_o           <= data_push || flush_push;
      bus_addr_valid_o <= hdr_valid && (own_match || bcast_match);
      if (stop_i) begin
        xfer_q    <= XFER_NONE;
        pushed_q  <= 1'b0;
        ack_req_o <= 1'b0;
      end else if (hdr_valid) begin
        // Reads are NACKed, there is no TX path
        ack_req_o <= (own_match || bcast_match) && !hdr_rnw;
        pushed_q  <= 1'b0;
        if (own_match && !hdr_rnw) begin
          xfer_q <= XFER_OWN_WR;
        end else if (bcast_match) begin
          xfer_q <= XFER_BCAST;
        end else begin
          xfer_q <= XFER_OTHER;
        end
      end else if (data_valid) begin
        ack_req_o <= 1'b0;
        if (data_push) begin
          pushed_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid) begin
      bus_addr_o <= byte_i.data;
    end
    if (data_push) begin
      entry_o.data  <= byte_i.data;
      entry_o.flush <= 1'b0;
    end else if (flush_push) begin
      entry_o.data  <= '0;
      entry_o.flush <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rx_flow.sv
// RX buffer of data and flush entries driving the RX queue write port
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"
`default_nettype none

module rx_flow
  import i3c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       push_i,
  input  rx_entry_t  entry_i,
  input  logic       rx_queue_wready_i,
  output logic       rx_queue_wvalid_o,
  output logic       rx_queue_wflush_o,
  output logic [7:0] rx_queue_wdata_o,
  output logic       rx_overflow_o
);

  localparam int DEPTH = `RX_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(DEPTH);

  rx_entry_t        buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  rx_entry_t        head;
  logic             not_empty;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign head      = buf_q[rd_ptr_q];
  assign not_empty = (count_q != '0);
  assign full      = (count_q == FULL_CNT);
  assign wr_en     = push_i && !full;

  // Flush leaves on its own, data waits for wready
  assign rx_queue_wvalid_o = not_empty && !head.flush;
  assign rx_queue_wflush_o = not_empty && head.flush;
  assign rx_queue_wdata_o  = head.data;
  assign rd_en = rx_queue_wflush_o || (rx_queue_wvalid_o && rx_queue_wready_i);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      buf_q[wr_ptr_q] <= entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      rx_overflow_o <= 1'b0;
    end else begin
      rx_overflow_o <= push_i && full;
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Count never passes the depth and agrees with the pointers
  a_count_ptr_match: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (count_q <= FULL_CNT) && (count_q[PTR_W-1:0] == (wr_ptr_q - rd_ptr_q))
  );

  a_wdata_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (rx_queue_wvalid_o && !rx_queue_wready_i) |=>
      (rx_queue_wvalid_o && $stable(rx_queue_wdata_o))
  );

endmodule

`default_nettype wire

//--- controller_standby_i3c.sv
// I3C standby controller top level with the monitor, deserializer, filter and RX flow
`timescale 1ns/1ps
`default_nettype none

module controller_standby_i3c
  import i3c_standby_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       i3c_standby_en_i,

  // SDA/SCL pads
  input  logic       ctrl_scl_i,
  input  logic       ctrl_sda_i,
  output logic       ctrl_scl_o,
  output logic       ctrl_sda_o,

  // Dynamic address from DAA or the CSRs
  input  logic [6:0] dyn_addr_i,
  input  logic       dyn_addr_valid_i,

  // RX data queue
  input  logic       rx_queue_wready_i,
  output logic       rx_queue_wvalid_o,
  output logic [7:0] rx_queue_wdata_o,
  output logic       rx_queue_wflush_o,
  output logic       rx_overflow_o,

  // Bus conditions and received header
  output logic       bus_start_o,
  output logic       bus_stop_o,
  output logic [7:0] bus_addr_o,
  output logic       bus_addr_valid_o
);

  bus_event_t bus_event;
  logic       ack_req;
  logic       byte_valid;
  rx_byte_t   rx_byte;
  logic       push;
  rx_entry_t  entry;

  bus_monitor xbus_monitor (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .enable_i (i3c_standby_en_i),
    .scl_i    (ctrl_scl_i),
    .sda_i    (ctrl_sda_i),
    .event_o  (bus_event)
  );

  sdr_deserializer xsdr_deserializer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .event_i      (bus_event),
    .ack_req_i    (ack_req),
    .byte_valid_o (byte_valid),
    .byte_o       (rx_byte),
    .sda_o        (ctrl_sda_o)
  );

  target_addr_filter xtarget_addr_filter (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .byte_valid_i     (byte_valid),
    .byte_i           (rx_byte),
    .stop_i           (bus_event.stop),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .ack_req_o        (ack_req),
    .push_o           (push),
    .entry_o          (entry),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o)
  );

  rx_flow xrx_flow (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .push_i            (push),
    .entry_i           (entry),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wflush_o (rx_queue_wflush_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_overflow_o     (rx_overflow_o)
  );

  // SCL is never stretched
  assign ctrl_scl_o = 1'b1;

  // Repeated START included
  assign bus_start_o = bus_event.start;
  assign bus_stop_o  = bus_event.stop;

endmodule

`default_nettype wire

//--- tb_controller_standby_i3c.sv
// Testbench for the I3C standby receive path with bus driver, LFSR stimulus and RX queue model
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"
`default_nettype none

module tb_controller_standby_i3c;

  localparam int          NUM_XFERS       = 24;
  localparam int          FRAME_CYCLES    = 1100;
  localparam int          DRAIN_CYCLES    = 4000;
  localparam int          WATCHDOG_CYCLES = (NUM_XFERS + 4) * FRAME_CYCLES + 4 * DRAIN_CYCLES;
  localparam int          OVF_BYTES       = `RX_BUF_DEPTH + 2;
  localparam logic [31:0] SEED            = 32'h3f35d485;
  localparam logic [6:0]  DYN_ADDR        = 7'h35;
  localparam logic [6:0]  BCAST_ADDR      = 7'h7E;

  logic       clk;
  logic       arst_n;
  logic       en;
  logic       tb_scl;
  logic       tb_sda;
  logic       sda_bus;
  logic       dyn_valid;
  logic       wready;
  logic       rdy_hold_low;
  logic       ctrl_scl;
  logic       ctrl_sda;
  logic       wvalid;
  logic [7:0] wdata;
  logic       wflush;
  logic       overflow;
  logic       bus_start;
  logic       bus_stop;
  logic [7:0] bus_addr;
  logic       bus_addr_valid;

  logic [31:0] main_lfsr;
  logic [31:0] rdy_lfsr;
  logic [8:0]  exp_q[$];
  logic [7:0]  exp_hdr;
  string       test_name;
  int          errors;
  int          checks;
  int          exp_starts;
  int          exp_stops;
  int          exp_addr_valids;
  int          exp_overflows;

  // Written by the output monitor only
  int obs_idx = 0;
  int mon_errors = 0;
  int act_starts = 0;
  int act_stops = 0;
  int act_addr_valids = 0;
  int act_overflows = 0;
  int activity = 0;

  // Open-drain wired AND
  assign sda_bus = tb_sda & ctrl_sda;

  controller_standby_i3c controller_standby_i3c_inst (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .i3c_standby_en_i  (en),
    .ctrl_scl_i        (tb_scl),
    .ctrl_sda_i        (sda_bus),
    .ctrl_scl_o        (ctrl_scl),
    .ctrl_sda_o        (ctrl_sda),
    .dyn_addr_i        (DYN_ADDR),
    .dyn_addr_valid_i  (dyn_valid),
    .rx_queue_wready_i (wready),
    .rx_queue_wvalid_o (wvalid),
    .rx_queue_wdata_o  (wdata),
    .rx_queue_wflush_o (wflush),
    .rx_overflow_o     (overflow),
    .bus_start_o       (bus_start),
    .bus_stop_o        (bus_stop),
    .bus_addr_o        (bus_addr),
    .bus_addr_valid_o  (bus_addr_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h80200003;
    end
    return n;
  endfunction

  task automatic draw(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      main_lfsr = lfsr_next(main_lfsr);
      v = {v[30:0], main_lfsr[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
  endtask

  task automatic send_start(input logic repeated);
    if (repeated) begin
      tb_scl = 1'b0;
      wait_cycles(2);
      tb_sda = 1'b1;
      wait_cycles(6);
      tb_scl = 1'b1;
      wait_cycles(8);
    end
    tb_sda = 1'b0;
    wait_cycles(8);
  endtask

  task automatic send_stop();
    tb_scl = 1'b0;
    wait_cycles(2);
    tb_sda = 1'b0;
    wait_cycles(6);
    tb_scl = 1'b1;
    wait_cycles(8);
    tb_sda = 1'b1;
    wait_cycles(8);
  endtask

  // SDA sampled in the middle of the high phase
  task automatic send_bit(input logic b, output logic seen);
    tb_scl = 1'b0;
    wait_cycles(2);
    tb_sda = b;
    wait_cycles(6);
    tb_scl = 1'b1;
    wait_cycles(4);
    seen = sda_bus;
    wait_cycles(4);
  endtask

  task automatic send_byte(input logic [7:0] data, input logic ninth, output logic ninth_seen);
    logic [7:0] sh;
    logic       seen;
    sh = data;
    repeat (8) begin
      send_bit(sh[7], seen);
      sh = {sh[6:0], 1'b0};
    end
    send_bit(ninth, ninth_seen);
  endtask

  // Entries past keep_max are expected to be dropped by a full buffer
  task automatic do_transfer(input logic repeated, input logic [6:0] addr, input logic rnw,
                             input int nbytes, input logic [7:0] bad_mask,
                             input logic stop, input int keep_max);
    logic        match;
    logic        own_wr;
    logic        ack_exp;
    logic        ack_bit;
    logic        tbit;
    logic        t_seen;
    logic [7:0]  bad;
    logic [7:0]  data;
    logic [31:0] r;
    int          pushes;
    match   = (addr == `STATIC_ADDR) || (dyn_valid && (addr == DYN_ADDR)) ||
              (addr == BCAST_ADDR);
    own_wr  = en && !rnw && ((addr == `STATIC_ADDR) || (dyn_valid && (addr == DYN_ADDR)));
    ack_exp = en && match && !rnw;
    bad     = bad_mask;
    pushes  = 0;
    if (en) begin
      exp_starts++;
      if (match) begin
        exp_addr_valids++;
      end
    end
    exp_hdr = {addr, rnw};
    send_start(repeated);
    send_byte({addr, rnw}, 1'b1, ack_bit);
    checks++;
    if (ack_bit !== !ack_exp) begin
      report_mismatch("address_ack", 32'(!ack_exp), 32'(ack_bit));
    end
    for (int b = 0; b < nbytes; b++) begin
      draw(8, r);
      data = r[7:0];
      if (own_wr && !bad[0]) begin
        if (pushes < keep_max) begin
          exp_q.push_back({1'b0, data});
        end else begin
          exp_overflows++;
        end
        pushes++;
      end
      // Odd parity over data and T-bit unless corrupted
      tbit = bad[0] ? ^data : ~^data;
      send_byte(data, tbit, t_seen);
      // The target never pulls SDA in the T-bit slot
      checks++;
      if (t_seen !== tbit) begin
        report_mismatch("t_bit", 32'(tbit), 32'(t_seen));
      end
      bad = {1'b0, bad[7:1]};
    end
    if (stop) begin
      if (own_wr && (pushes > 0)) begin
        if (pushes < keep_max) begin
          exp_q.push_back(9'h100);
        end else begin
          exp_overflows++;
        end
      end
      if (en) begin
        exp_stops++;
      end
      send_stop();
    end
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while ((obs_idx < exp_q.size()) && (n < DRAIN_CYCLES)) begin
      @(negedge clk);
      n++;
    end
    wait_cycles(16);
    checks++;
    if (obs_idx != exp_q.size()) begin
      errors++;
      $display("Error in %s: %0d expected RX queue entries never arrived", name,
               exp_q.size() - obs_idx);
    end
  endtask

  initial begin
    rdy_lfsr = SEED;
    wready = 1'b0;
    forever begin
      @(negedge clk);
      rdy_lfsr = lfsr_next(rdy_lfsr);
      wready = rdy_hold_low ? 1'b0 : rdy_lfsr[0];
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      if (bus_start) act_starts++;
      if (bus_stop) act_stops++;
      if (overflow) act_overflows++;
      if (bus_start || bus_stop || bus_addr_valid || wvalid || wflush || overflow || !ctrl_sda) begin
        activity++;
      end
      if (ctrl_scl !== 1'b1) begin
        mon_errors++;
        $display("Error in %s: ctrl_scl_o pulled SCL low", test_name);
      end
      if (bus_addr_valid) begin
        act_addr_valids++;
        if (bus_addr !== exp_hdr) begin
          mon_errors++;
          $display("Mismatch address_header: expected %0h, actual %0h", exp_hdr, bus_addr);
        end
      end
      if (wvalid && wflush) begin
        mon_errors++;
        $display("Error in %s: wvalid and wflush high in the same cycle", test_name);
      end
      if ((wvalid && wready) || wflush) begin
        if (obs_idx >= exp_q.size()) begin
          mon_errors++;
          $display("Error in %s: RX queue entry appeared that the model did not expect",
                   test_name);
        end else begin
          if (exp_q[obs_idx] !== (wflush ? 9'h100 : {1'b0, wdata})) begin
            mon_errors++;
            $display("Mismatch %s: expected %0h, actual %0h", test_name, exp_q[obs_idx],
                     wflush ? 9'h100 : {1'b0, wdata});
          end
          obs_idx++;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [6:0]  addr;
    logic        rnw;
    logic        stop;
    logic        repeated;
    logic [7:0]  bad;
    int          nbytes;
    int          ovf_before;
    int          act_before;
    int          total;
    arst_n = 1'b0;
    en = 1'b1;
    tb_scl = 1'b1;
    tb_sda = 1'b1;
    dyn_valid = 1'b0;
    rdy_hold_low = 1'b0;
    main_lfsr = SEED;
    exp_hdr = '0;
    test_name = "reset";
    errors = 0;
    checks = 0;
    exp_starts = 0;
    exp_stops = 0;
    exp_addr_valids = 0;
    exp_overflows = 0;
    wait_cycles(16);
    arst_n = 1'b1;
    wait_cycles(20);

    // Random headers, payloads, corrupted T-bits and repeated STARTs
    test_name = "write_data";
    repeated = 1'b0;
    for (int t = 0; t < NUM_XFERS; t++) begin
      draw(2, r);
      case (r[1:0])
        2'd0: addr = `STATIC_ADDR;
        2'd1: addr = DYN_ADDR;
        2'd2: addr = BCAST_ADDR;
        default: begin
          draw(7, r);
          addr = r[6:0];
        end
      endcase
      draw(2, r);
      rnw = &r[1:0];
      draw(1, r);
      dyn_valid = r[0];
      draw(3, r);
      nbytes = 1 + int'(r[2:0]) % 6;
      bad = '0;
      repeat (8) begin
        draw(3, r);
        bad = {bad[6:0], (r[2:0] == 3'd0)};
      end
      draw(2, r);
      stop = (t == NUM_XFERS - 1) || (r[1:0] != 2'd0);
      do_transfer(repeated, addr, rnw, nbytes, bad, stop, 999);
      repeated = !stop;
      if (stop) begin
        wait_cycles(16);
      end
    end
    wait_drain("write_data");

    // Full buffer with wready held low
    test_name = "overflow";
    rdy_hold_low = 1'b1;
    ovf_before = act_overflows;
    do_transfer(1'b0, `STATIC_ADDR, 1'b0, OVF_BYTES, 8'h00, 1'b1, `RX_BUF_DEPTH);
    wait_cycles(32);
    checks++;
    if ((act_overflows - ovf_before) != (OVF_BYTES + 1 - `RX_BUF_DEPTH)) begin
      report_mismatch("overflow", OVF_BYTES + 1 - `RX_BUF_DEPTH, act_overflows - ovf_before);
    end
    rdy_hold_low = 1'b0;
    wait_drain("overflow");

    // Disabled target stays silent
    test_name = "enable";
    en = 1'b0;
    wait_cycles(8);
    act_before = activity;
    do_transfer(1'b0, `STATIC_ADDR, 1'b0, 3, 8'h00, 1'b1, 999);
    wait_cycles(16);
    checks++;
    if (activity != act_before) begin
      errors++;
      $display("Error in enable: outputs were active while the target was disabled");
    end
    en = 1'b1;
    wait_cycles(8);
    test_name = "reenable";
    do_transfer(1'b0, `STATIC_ADDR, 1'b0, 2, 8'h00, 1'b1, 999);
    wait_drain("reenable");

    checks += 4;
    if (act_starts != exp_starts) report_mismatch("bus_start", exp_starts, act_starts);
    if (act_stops != exp_stops) report_mismatch("bus_stop", exp_stops, act_stops);
    if (act_addr_valids != exp_addr_valids) begin
      report_mismatch("bus_addr_valid", exp_addr_valids, act_addr_valids);
    end
    if (act_overflows != exp_overflows) begin
      report_mismatch("overflow_total", exp_overflows, act_overflows);
    end

    total = errors + mon_errors;
    $display("Checks: %0d, RX entries: %0d, errors: %0d", checks, obs_idx, total);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- controller_standby_i3c.f
+incdir+.
i3c_standby_pkg.sv
bus_monitor.sv
sdr_deserializer.sv
target_addr_filter.sv
rx_flow.sv
controller_standby_i3c.sv
tb_controller_standby_i3c.sv

//--- Makefile
TOP := tb_controller_standby_i3c

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f controller_standby_i3c.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
